/* common/decode_pkg.sv */
package decode_pkg;

  //////////////////////////////
  // Widths and basic types
  //////////////////////////////

  localparam int xlen     = 32; // Data and instruction width
  localparam int num_regs = 32; // Architectural registers

  typedef logic [xlen-1:0]             word_t;
  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // RV32I major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011
  } major_op_e;

  // Internal opcode handed to execute
  typedef enum logic [5:0] {
    iop_add,
    iop_sub,
    iop_and,
    iop_or,
    iop_xor,
    iop_slt,
    iop_sltu,
    iop_sra,
    iop_srl,
    iop_sll,
    iop_addi,
    iop_andi,
    iop_ori,
    iop_xori,
    iop_slti,
    iop_sltiu,
    iop_srai,
    iop_srli,
    iop_slli,
    iop_lui,
    iop_auipc,
    iop_lw,
    iop_sw,
    iop_jal,
    iop_jalr,
    iop_beq,
    iop_bne,
    iop_blt,
    iop_bge,
    iop_bltu,
    iop_bgeu,
    iop_invalid  // Unknown encoding
  } iop_e;

  // Immediate layouts, none for R-type and invalid
  typedef enum logic [2:0] {
    imm_none,
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_fmt_e;

endpackage

/* common/dec_if.sv */
// Decoded instruction record, decoder to issue control
interface dec_if;

  decode_pkg::iop_e     op;
  decode_pkg::word_t    imm;     // Sign-extended immediate
  decode_pkg::reg_idx_t rs1;
  decode_pkg::reg_idx_t rs2;
  decode_pkg::reg_idx_t rd;
  logic                 use_rs1; // Source really read
  logic                 use_rs2;
  logic                 is_br;   // Conditional branch
  logic                 is_jmp;  // JAL or JALR
  logic                 rd_mem;  // Load
  logic                 wr_mem;  // Store
  logic                 wr_reg;  // Writes a nonzero rd

  modport src (
    output op, imm, rs1, rs2, rd,
    output use_rs1, use_rs2,
    output is_br, is_jmp, rd_mem, wr_mem, wr_reg
  );

  modport dst (
    input op, imm, rs1, rs2, rd,
    input use_rs1, use_rs2,
    input is_br, is_jmp, rd_mem, wr_mem, wr_reg
  );

endinterface

/* decode/inst_decoder.sv */
module inst_decoder (
  input  decode_pkg::word_t inst,
  dec_if.src                dec
);

  // funct3 codes of the ALU group
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  // Memory, jump and branch funct3
  localparam logic [2:0] f3_word    = 3'b010; // LW and SW
  localparam logic [2:0] f3_jalr    = 3'b000;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_blt     = 3'b100;
  localparam logic [2:0] f3_bge     = 3'b101;
  localparam logic [2:0] f3_bltu    = 3'b110;
  localparam logic [2:0] f3_bgeu    = 3'b111;
  // funct7 variants
  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_alt     = 7'b0100000; // SUB and SRA

  decode_pkg::major_op_e major;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  decode_pkg::reg_idx_t  rd;
  decode_pkg::iop_e      op;
  decode_pkg::imm_fmt_e  fmt;
  logic                  r_type;

  assign major  = decode_pkg::major_op_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];

  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];
  assign dec.rd  = rd;

  //////////////////////////////
  // Opcode decode
  //////////////////////////////

  always_comb begin
    op = decode_pkg::iop_invalid;
    case (major)
      decode_pkg::opc_op: begin
        if (funct7 == f7_base) begin
          case (funct3)
            f3_add_sub: op = decode_pkg::iop_add;
            f3_sll:     op = decode_pkg::iop_sll;
            f3_slt:     op = decode_pkg::iop_slt;
            f3_sltu:    op = decode_pkg::iop_sltu;
            f3_xor:     op = decode_pkg::iop_xor;
            f3_srl_sra: op = decode_pkg::iop_srl;
            f3_or:      op = decode_pkg::iop_or;
            f3_and:     op = decode_pkg::iop_and;
          endcase
        end else if (funct7 == f7_alt) begin
          if (funct3 == f3_add_sub)
            op = decode_pkg::iop_sub;
          else if (funct3 == f3_srl_sra)
            op = decode_pkg::iop_sra;
        end
      end
      decode_pkg::opc_op_imm: begin
        case (funct3)
          f3_add_sub: op = decode_pkg::iop_addi;
          f3_slt:     op = decode_pkg::iop_slti;
          f3_sltu:    op = decode_pkg::iop_sltiu;
          f3_xor:     op = decode_pkg::iop_xori;
          f3_or:      op = decode_pkg::iop_ori;
          f3_and:     op = decode_pkg::iop_andi;
          f3_sll: begin
            if (funct7 == f7_base) op = decode_pkg::iop_slli;
          end
          f3_srl_sra: begin
            if (funct7 == f7_base)
              op = decode_pkg::iop_srli;
            else if (funct7 == f7_alt)
              op = decode_pkg::iop_srai;
          end
        endcase
      end
      decode_pkg::opc_lui:   op = decode_pkg::iop_lui;
      decode_pkg::opc_auipc: op = decode_pkg::iop_auipc;
      decode_pkg::opc_jal:   op = decode_pkg::iop_jal;
      decode_pkg::opc_jalr: begin
        if (funct3 == f3_jalr) op = decode_pkg::iop_jalr;
      end
      decode_pkg::opc_load: begin
        if (funct3 == f3_word) op = decode_pkg::iop_lw;
      end
      decode_pkg::opc_store: begin
        if (funct3 == f3_word) op = decode_pkg::iop_sw;
      end
      decode_pkg::opc_branch: begin
        case (funct3)
          f3_beq:  op = decode_pkg::iop_beq;
          f3_bne:  op = decode_pkg::iop_bne;
          f3_blt:  op = decode_pkg::iop_blt;
          f3_bge:  op = decode_pkg::iop_bge;
          f3_bltu: op = decode_pkg::iop_bltu;
          f3_bgeu: op = decode_pkg::iop_bgeu;
          default: op = decode_pkg::iop_invalid; // 010 and 011 unused
        endcase
      end
      default: op = decode_pkg::iop_invalid;
    endcase
  end

  // Immediate format per opcode, R-type flagged apart
  always_comb begin
    fmt    = decode_pkg::imm_none;
    r_type = 1'b0;
    case (op)
      decode_pkg::iop_add, decode_pkg::iop_sub, decode_pkg::iop_and, decode_pkg::iop_or,
      decode_pkg::iop_xor, decode_pkg::iop_slt, decode_pkg::iop_sltu, decode_pkg::iop_sra,
      decode_pkg::iop_srl, decode_pkg::iop_sll:
        r_type = 1'b1;
      decode_pkg::iop_addi, decode_pkg::iop_andi, decode_pkg::iop_ori, decode_pkg::iop_xori,
      decode_pkg::iop_slti, decode_pkg::iop_sltiu, decode_pkg::iop_srai, decode_pkg::iop_srli,
      decode_pkg::iop_slli, decode_pkg::iop_lw, decode_pkg::iop_jalr:
        fmt = decode_pkg::imm_i;
      decode_pkg::iop_sw:
        fmt = decode_pkg::imm_s;
      decode_pkg::iop_beq, decode_pkg::iop_bne, decode_pkg::iop_blt, decode_pkg::iop_bge,
      decode_pkg::iop_bltu, decode_pkg::iop_bgeu:
        fmt = decode_pkg::imm_b;
      decode_pkg::iop_lui, decode_pkg::iop_auipc:
        fmt = decode_pkg::imm_u;
      decode_pkg::iop_jal:
        fmt = decode_pkg::imm_j;
      default: ;
    endcase
  end

  //////////////////////////////
  // Immediate and flags
  //////////////////////////////

  always_comb begin
    case (fmt)
      decode_pkg::imm_i: dec.imm = {{20{inst[31]}}, inst[31:20]};
      decode_pkg::imm_s: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      decode_pkg::imm_b: dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                    inst[11:8], 1'b0};
      decode_pkg::imm_u: dec.imm = {inst[31:12], 12'b0};
      decode_pkg::imm_j: dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
      default:           dec.imm = '0;
    endcase
  end

  assign dec.op      = op;
  assign dec.use_rs1 = r_type || (fmt inside {decode_pkg::imm_i, decode_pkg::imm_s,
                                              decode_pkg::imm_b});
  assign dec.use_rs2 = r_type || (fmt inside {decode_pkg::imm_s, decode_pkg::imm_b});
  assign dec.is_br   = op inside {decode_pkg::iop_beq, decode_pkg::iop_bne, decode_pkg::iop_blt,
                                  decode_pkg::iop_bge, decode_pkg::iop_bltu, decode_pkg::iop_bgeu};
  assign dec.is_jmp  = op inside {decode_pkg::iop_jal, decode_pkg::iop_jalr};
  assign dec.rd_mem  = (op == decode_pkg::iop_lw);
  assign dec.wr_mem  = (op == decode_pkg::iop_sw);

  // Stores, branches and bad encodings never write back
  assign dec.wr_reg  = !(dec.is_br || dec.wr_mem || op == decode_pkg::iop_invalid)
                       && (rd != '0);

endmodule

/* decode/reg_file.sv */
module reg_file (
  input  logic                 clk,
  input  logic                 reset,
  input  decode_pkg::reg_idx_t rs1,
  input  decode_pkg::reg_idx_t rs2,
  output decode_pkg::word_t    rs1_val,
  output decode_pkg::word_t    rs2_val,
  input  logic                 wb_wr_reg,
  input  decode_pkg::reg_idx_t wb_regno,
  input  decode_pkg::word_t    wb_regval
);

  decode_pkg::word_t regs [decode_pkg::num_regs];
  logic              wr_en;

  // x0 is hardwired to zero
  assign wr_en = wb_wr_reg && (wb_regno != '0);

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < decode_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_regno] <= wb_regval;
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Write-first bypass so a same-cycle write is seen
  assign rs1_val = (wr_en && wb_regno == rs1) ? wb_regval : regs[rs1];
  assign rs2_val = (wr_en && wb_regno == rs2) ? wb_regval : regs[rs2];

endmodule

/* decode/issue_ctrl.sv */
module issue_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fe_valid,
  input  decode_pkg::word_t    fe_pc,
  input  logic                 br_mispred,
  dec_if.dst                   dec,
  input  decode_pkg::word_t    rs1_val,
  input  decode_pkg::word_t    rs2_val,
  input  logic                 wb_wr_reg,
  input  decode_pkg::reg_idx_t wb_regno,
  output logic                 stall,
  output logic                 de_valid,
  output decode_pkg::word_t    de_pc,
  output decode_pkg::iop_e     de_op,
  output decode_pkg::word_t    de_rs1_val,
  output decode_pkg::word_t    de_rs2_val,
  output decode_pkg::word_t    de_imm,
  output logic                 de_is_br,
  output logic                 de_is_jmp,
  output logic                 de_rd_mem,
  output logic                 de_wr_mem,
  output logic                 de_wr_reg,
  output decode_pkg::reg_idx_t de_rd
);

  logic [decode_pkg::num_regs-1:0] in_use;      // Pending writes
  logic [decode_pkg::num_regs-1:0] in_use_next;
  logic                            hazard;
  logic                            accept;

  //////////////////////////////
  // Hazards and scoreboard
  //////////////////////////////

  assign hazard = (dec.use_rs1 && in_use[dec.rs1]) || (dec.use_rs2 && in_use[dec.rs2]);
  assign stall  = br_mispred || (fe_valid && hazard);
  assign accept = fe_valid && !stall;

  always_comb begin
    in_use_next = in_use;
    if (wb_wr_reg)
      in_use_next[wb_regno] = 1'b0;
    // Applied last so a new writer beats the write-back clear
    if (accept && dec.wr_reg)
      in_use_next[dec.rd] = 1'b1;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      in_use <= '0;
    else
      in_use <= in_use_next;
  end

  //////////////////////////////
  // Execute latch
  //////////////////////////////

  // Valid and flags, zeroed for a bubble
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de_valid  <= 1'b0;
      de_is_br  <= 1'b0;
      de_is_jmp <= 1'b0;
      de_rd_mem <= 1'b0;
      de_wr_mem <= 1'b0;
      de_wr_reg <= 1'b0;
    end else begin
      de_valid  <= accept;
      de_is_br  <= accept && dec.is_br;
      de_is_jmp <= accept && dec.is_jmp;
      de_rd_mem <= accept && dec.rd_mem;
      de_wr_mem <= accept && dec.wr_mem;
      de_wr_reg <= accept && dec.wr_reg;
    end
  end

  // Payload only means something with de_valid
  always_ff @(posedge clk) begin
    de_pc      <= fe_pc;
    de_op      <= dec.op;
    de_rs1_val <= rs1_val;
    de_rs2_val <= rs2_val;
    de_imm     <= dec.imm;
    de_rd      <= dec.rd;
  end

endmodule

/* logic/decode_stage.sv */
module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fe_valid,
  input  decode_pkg::word_t    fe_inst,
  input  decode_pkg::word_t    fe_pc,
  input  logic                 br_mispred,   // Level from execute
  input  logic                 wb_wr_reg,
  input  decode_pkg::reg_idx_t wb_regno,
  input  decode_pkg::word_t    wb_regval,
  output logic                 stall,        // Hold request to fetch
  output logic                 de_valid,
  output decode_pkg::word_t    de_pc,
  output decode_pkg::iop_e     de_op,
  output decode_pkg::word_t    de_rs1_val,
  output decode_pkg::word_t    de_rs2_val,
  output decode_pkg::word_t    de_imm,
  output logic                 de_is_br,
  output logic                 de_is_jmp,
  output logic                 de_rd_mem,
  output logic                 de_wr_mem,
  output logic                 de_wr_reg,
  output decode_pkg::reg_idx_t de_rd
);

  dec_if             dec_bus ();
  decode_pkg::word_t rs1_val;
  decode_pkg::word_t rs2_val;

  inst_decoder u_inst_decoder (
    .inst (fe_inst),
    .dec  (dec_bus.src)
  );

  // Source indices come straight from the decoder
  reg_file u_reg_file (
    .clk       (clk),
    .reset     (reset),
    .rs1       (dec_bus.rs1),
    .rs2       (dec_bus.rs2),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .wb_wr_reg (wb_wr_reg),
    .wb_regno  (wb_regno),
    .wb_regval (wb_regval)
  );

  issue_ctrl u_issue_ctrl (
    .clk        (clk),
    .reset      (reset),
    .fe_valid   (fe_valid),
    .fe_pc      (fe_pc),
    .br_mispred (br_mispred),
    .dec        (dec_bus.dst),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .wb_wr_reg  (wb_wr_reg),
    .wb_regno   (wb_regno),
    .stall      (stall),
    .de_valid   (de_valid),
    .de_pc      (de_pc),
    .de_op      (de_op),
    .de_rs1_val (de_rs1_val),
    .de_rs2_val (de_rs2_val),
    .de_imm     (de_imm),
    .de_is_br   (de_is_br),
    .de_is_jmp  (de_is_jmp),
    .de_rd_mem  (de_rd_mem),
    .de_wr_mem  (de_wr_mem),
    .de_wr_reg  (de_wr_reg),
    .de_rd      (de_rd)
  );

endmodule

/* tests/tb_ref.svh */
`ifndef tb_ref_svh
`define tb_ref_svh

// Expected decode of one instruction word
typedef struct packed {
  decode_pkg::iop_e     op;
  decode_pkg::word_t    imm;
  decode_pkg::reg_idx_t rd;
  logic                 use_rs1;
  logic                 use_rs2;
  logic                 is_br;
  logic                 is_jmp;
  logic                 rd_mem;
  logic                 wr_mem;
  logic                 wr_reg;
} dec_ref_t;

//////////////////////////////
// Immediate helpers
//////////////////////////////

// Sign-extend the low n bits of v
function automatic decode_pkg::word_t sext(input decode_pkg::word_t v, input int n);
  decode_pkg::word_t t;
  t = v << (32 - n);
  return decode_pkg::word_t'($signed(t) >>> (32 - n));
endfunction

function automatic decode_pkg::word_t imm_i_of(input decode_pkg::word_t w);
  return sext(32'(w[31:20]), 12);
endfunction

function automatic decode_pkg::word_t imm_s_of(input decode_pkg::word_t w);
  return sext(32'({w[31:25], w[11:7]}), 12);
endfunction

function automatic decode_pkg::word_t imm_b_of(input decode_pkg::word_t w);
  return sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
endfunction

function automatic decode_pkg::word_t imm_u_of(input decode_pkg::word_t w);
  return {w[31:12], 12'h000};
endfunction

function automatic decode_pkg::word_t imm_j_of(input decode_pkg::word_t w);
  return sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
endfunction

//////////////////////////////
// Reference decode
//////////////////////////////

// OP and OP-IMM share funct3, funct7 picks the variant
function automatic decode_pkg::iop_e alu_op(input logic [2:0] f3, input logic [6:0] f7,
                                            input logic imm);
  logic base;
  logic alt;
  base   = (f7 == 7'h00);
  alt    = (f7 == 7'h20);
  alu_op = decode_pkg::iop_invalid;
  case (f3)
    3'd0: begin
      if (imm)
        alu_op = decode_pkg::iop_addi;
      else if (base)
        alu_op = decode_pkg::iop_add;
      else if (alt)
        alu_op = decode_pkg::iop_sub;
    end
    3'd1: if (base) alu_op = imm ? decode_pkg::iop_slli : decode_pkg::iop_sll;
    3'd2: if (imm || base) alu_op = imm ? decode_pkg::iop_slti : decode_pkg::iop_slt;
    3'd3: if (imm || base) alu_op = imm ? decode_pkg::iop_sltiu : decode_pkg::iop_sltu;
    3'd4: if (imm || base) alu_op = imm ? decode_pkg::iop_xori : decode_pkg::iop_xor;
    3'd5: begin
      if (base)
        alu_op = imm ? decode_pkg::iop_srli : decode_pkg::iop_srl;
      else if (alt)
        alu_op = imm ? decode_pkg::iop_srai : decode_pkg::iop_sra;
    end
    3'd6: if (imm || base) alu_op = imm ? decode_pkg::iop_ori : decode_pkg::iop_or;
    default: if (imm || base) alu_op = imm ? decode_pkg::iop_andi : decode_pkg::iop_and;
  endcase
endfunction

function automatic dec_ref_t ref_decode(input decode_pkg::word_t w);
  dec_ref_t   e;
  logic [6:0] opc;
  logic [2:0] f3;
  e    = '0;
  opc  = w[6:0];
  f3   = w[14:12];
  e.rd = w[11:7];
  e.op = decode_pkg::iop_invalid;
  case (opc)
    7'h33: e.op = alu_op(f3, w[31:25], 1'b0);
    7'h13: e.op = alu_op(f3, w[31:25], 1'b1);
    7'h37: e.op = decode_pkg::iop_lui;
    7'h17: e.op = decode_pkg::iop_auipc;
    7'h6f: e.op = decode_pkg::iop_jal;
    7'h67: if (f3 == 3'd0) e.op = decode_pkg::iop_jalr;
    7'h03: if (f3 == 3'd2) e.op = decode_pkg::iop_lw;
    7'h23: if (f3 == 3'd2) e.op = decode_pkg::iop_sw;
    7'h63: begin
      case (f3)
        3'd0: e.op = decode_pkg::iop_beq;
        3'd1: e.op = decode_pkg::iop_bne;
        3'd4: e.op = decode_pkg::iop_blt;
        3'd5: e.op = decode_pkg::iop_bge;
        3'd6: e.op = decode_pkg::iop_bltu;
        3'd7: e.op = decode_pkg::iop_bgeu;
        default: ;
      endcase
    end
    default: ;
  endcase
  // Bad encodings keep every flag and the immediate at zero
  if (e.op != decode_pkg::iop_invalid) begin
    e.use_rs1 = opc inside {7'h33, 7'h13, 7'h03, 7'h67, 7'h23, 7'h63};
    e.use_rs2 = opc inside {7'h33, 7'h23, 7'h63};
    e.is_br   = (opc == 7'h63);
    e.is_jmp  = opc inside {7'h6f, 7'h67};
    e.rd_mem  = (opc == 7'h03);
    e.wr_mem  = (opc == 7'h23);
    e.wr_reg  = !e.is_br && !e.wr_mem && (e.rd != 5'd0);
    case (opc)
      7'h13, 7'h03, 7'h67: e.imm = imm_i_of(w);
      7'h23:               e.imm = imm_s_of(w);
      7'h63:               e.imm = imm_b_of(w);
      7'h37, 7'h17:        e.imm = imm_u_of(w);
      7'h6f:               e.imm = imm_j_of(w);
      default:             e.imm = '0; // R-type
    endcase
  end
  return e;
endfunction

`endif

/* tests/tb_decode_stage.sv */
module tb_decode_stage;

  `include "tb_ref.svh"

  localparam int half_period = 20;
  localparam int drive_delay = 2;  // Inputs change this long after the rising edge
  localparam int max_wait    = 20; // Cycles before a wait gives up

  logic                 clk;
  logic                 reset;
  logic                 fe_valid;
  decode_pkg::word_t    fe_inst;
  decode_pkg::word_t    fe_pc;
  logic                 br_mispred;
  logic                 wb_wr_reg;
  decode_pkg::reg_idx_t wb_regno;
  decode_pkg::word_t    wb_regval;
  logic                 stall;
  logic                 de_valid;
  decode_pkg::word_t    de_pc;
  decode_pkg::iop_e     de_op;
  decode_pkg::word_t    de_rs1_val;
  decode_pkg::word_t    de_rs2_val;
  decode_pkg::word_t    de_imm;
  logic                 de_is_br;
  logic                 de_is_jmp;
  logic                 de_rd_mem;
  logic                 de_wr_mem;
  logic                 de_wr_reg;
  decode_pkg::reg_idx_t de_rd;

  // Model of the register file and scoreboard
  decode_pkg::word_t model_regs [decode_pkg::num_regs];
  logic [31:0]       model_busy;
  dec_ref_t          exp_dec;     // Expected latch content after the next edge
  logic              exp_valid;
  decode_pkg::word_t exp_pc;
  decode_pkg::word_t exp_rs1;
  decode_pkg::word_t exp_rs2;

  int    errors;
  int    checks;
  int    tests;
  int    failed_tests;
  int    test_errs;
  int    seed_ret;
  string test_name;

  decode_stage u_decode_stage (
    .clk        (clk),
    .reset      (reset),
    .fe_valid   (fe_valid),
    .fe_inst    (fe_inst),
    .fe_pc      (fe_pc),
    .br_mispred (br_mispred),
    .wb_wr_reg  (wb_wr_reg),
    .wb_regno   (wb_regno),
    .wb_regval  (wb_regval),
    .stall      (stall),
    .de_valid   (de_valid),
    .de_pc      (de_pc),
    .de_op      (de_op),
    .de_rs1_val (de_rs1_val),
    .de_rs2_val (de_rs2_val),
    .de_imm     (de_imm),
    .de_is_br   (de_is_br),
    .de_is_jmp  (de_is_jmp),
    .de_rd_mem  (de_rd_mem),
    .de_wr_mem  (de_wr_mem),
    .de_wr_reg  (de_wr_reg),
    .de_rd      (de_rd)
  );

  always #(half_period) clk = ~clk;

  //////////////////////////////
  // Compare process
  //////////////////////////////

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Register read as the bypass sees it
  function automatic decode_pkg::word_t model_read(input decode_pkg::reg_idx_t idx);
    if (idx == 5'd0)
      return '0;
    if (wb_wr_reg && wb_regno == idx)
      return wb_regval;
    return model_regs[idx];
  endfunction

  task automatic check_latch();
    check_field("de_valid", 32'(de_valid), 32'(exp_valid));
    check_field("de_is_br", 32'(de_is_br), 32'(exp_dec.is_br));
    check_field("de_is_jmp", 32'(de_is_jmp), 32'(exp_dec.is_jmp));
    check_field("de_rd_mem", 32'(de_rd_mem), 32'(exp_dec.rd_mem));
    check_field("de_wr_mem", 32'(de_wr_mem), 32'(exp_dec.wr_mem));
    check_field("de_wr_reg", 32'(de_wr_reg), 32'(exp_dec.wr_reg));
    if (exp_valid) begin  // Payload of a bubble is don't care
      check_field("de_pc", de_pc, exp_pc);
      check_field("de_op", 32'(de_op), 32'(exp_dec.op));
      check_field("de_imm", de_imm, exp_dec.imm);
      check_field("de_rd", 32'(de_rd), 32'(exp_dec.rd));
      check_field("de_rs1_val", de_rs1_val, exp_rs1);
      check_field("de_rs2_val", de_rs2_val, exp_rs2);
    end
  endtask

  task automatic predict_next();
    dec_ref_t d;
    logic     hazard;
    logic     accept;
    d      = ref_decode(fe_inst);
    hazard = (d.use_rs1 && model_busy[fe_inst[19:15]]) ||
             (d.use_rs2 && model_busy[fe_inst[24:20]]);
    check_field("stall", 32'(stall), 32'(br_mispred || (fe_valid && hazard)));
    accept    = fe_valid && !br_mispred && !hazard;
    exp_valid = accept;
    exp_pc    = fe_pc;
    exp_rs1   = model_read(fe_inst[19:15]);
    exp_rs2   = model_read(fe_inst[24:20]);
    exp_dec   = accept ? d : '0;
    if (wb_wr_reg) begin
      if (wb_regno != 5'd0)
        model_regs[wb_regno] = wb_regval;
      model_busy[wb_regno] = 1'b0;
    end
    if (accept && d.wr_reg)
      model_busy[d.rd] = 1'b1;  // New writer beats the clear
  endtask

  // Outputs and stall are settled at the falling edge
  always @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < decode_pkg::num_regs; i++)
        model_regs[i] = '0;
      model_busy = '0;
      exp_valid  = 1'b0;
      exp_dec    = '0;
    end else begin
      check_latch();
      predict_next();
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #(drive_delay);
  endtask

  // Present one instruction and hold it until the stage takes it
  task automatic send(input decode_pkg::word_t inst);
    int n;
    fe_valid = 1'b1;
    fe_inst  = inst;
    fe_pc    = $urandom & 32'hffff_fffc;
    n        = 0;
    @(negedge clk);
    while (stall && n < max_wait) begin
      n++;
      @(negedge clk);
    end
    if (stall) begin
      errors++;
      $display("Timeout at %0t: instruction %h was never accepted", $time, inst);
    end
    next_cycle();
    fe_valid = 1'b0;
  endtask

  task automatic wb_write(input decode_pkg::reg_idx_t regno, input decode_pkg::word_t val);
    wb_wr_reg = 1'b1;
    wb_regno  = regno;
    wb_regval = val;
    next_cycle();
    wb_wr_reg = 1'b0;
  endtask

  // Issue and retire right away so no write stays pending
  task automatic run_inst(input decode_pkg::word_t inst);
    dec_ref_t d;
    d = ref_decode(inst);
    send(inst);
    if (d.wr_reg)
      wb_write(d.rd, $urandom);
  endtask

  function automatic decode_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  // One instruction per kept opcode with random fields from r
  function automatic decode_pkg::word_t build_inst(input int k, input decode_pkg::word_t r,
                                                   input decode_pkg::reg_idx_t rd);
    case (k)
      0:  return {7'h00, r[24:15], 3'd0, rd, 7'h33}; // ADD
      1:  return {7'h20, r[24:15], 3'd0, rd, 7'h33}; // SUB
      2:  return {7'h00, r[24:15], 3'd1, rd, 7'h33};
      3:  return {7'h00, r[24:15], 3'd2, rd, 7'h33};
      4:  return {7'h00, r[24:15], 3'd3, rd, 7'h33};
      5:  return {7'h00, r[24:15], 3'd4, rd, 7'h33};
      6:  return {7'h00, r[24:15], 3'd5, rd, 7'h33}; // SRL
      7:  return {7'h20, r[24:15], 3'd5, rd, 7'h33}; // SRA
      8:  return {7'h00, r[24:15], 3'd6, rd, 7'h33};
      9:  return {7'h00, r[24:15], 3'd7, rd, 7'h33};
      10: return {r[31:15], 3'd0, rd, 7'h13};        // ADDI
      11: return {r[31:15], 3'd2, rd, 7'h13};
      12: return {r[31:15], 3'd3, rd, 7'h13};
      13: return {r[31:15], 3'd4, rd, 7'h13};
      14: return {r[31:15], 3'd6, rd, 7'h13};
      15: return {r[31:15], 3'd7, rd, 7'h13};
      16: return {7'h00, r[24:15], 3'd1, rd, 7'h13}; // SLLI
      17: return {7'h00, r[24:15], 3'd5, rd, 7'h13}; // SRLI
      18: return {7'h20, r[24:15], 3'd5, rd, 7'h13}; // SRAI
      19: return {r[31:12], rd, 7'h37};              // LUI
      20: return {r[31:12], rd, 7'h17};              // AUIPC
      21: return {r[31:15], 3'd2, rd, 7'h03};        // LW
      22: return {r[31:15], 3'd2, r[11:7], 7'h23};   // SW
      23: return {r[31:12], rd, 7'h6f};              // JAL
      24: return {r[31:15], 3'd0, rd, 7'h67};        // JALR
      25: return {r[31:15], 3'd0, r[11:7], 7'h63};   // Branches from here
      26: return {r[31:15], 3'd1, r[11:7], 7'h63};
      27: return {r[31:15], 3'd4, r[11:7], 7'h63};
      28: return {r[31:15], 3'd5, r[11:7], 7'h63};
      29: return {r[31:15], 3'd6, r[11:7], 7'h63};
      default: return {r[31:15], 3'd7, r[11:7], 7'h63};
    endcase
  endfunction

  task automatic test_begin(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic test_end();
    next_cycle();  // Last result reaches the compare process
    tests++;
    if (errors != test_errs)
      failed_tests++;
    $display("test %s: %s, %0d mismatches", test_name,
             (errors == test_errs) ? "passed" : "failed", errors - test_errs);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int                   n;
    decode_pkg::word_t    r;
    decode_pkg::reg_idx_t rd;
    decode_pkg::word_t    inst;
    seed_ret     = $urandom(32'h6b28_8142);
    clk          = 1'b0;
    reset        = 1'b1;
    fe_valid     = 1'b0;
    fe_inst      = '0;
    fe_pc        = '0;
    br_mispred   = 1'b0;
    wb_wr_reg    = 1'b0;
    wb_regno     = '0;
    wb_regval    = '0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    repeat (8) @(posedge clk);
    #(drive_delay);
    reset = 1'b0;

    test_begin("reset");
    next_cycle();
    run_inst(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3)); // ADD x3, x1, x2 reads zeros
    test_end();

    test_begin("decode sweep");
    for (int k = 0; k < 31; k++) begin
      r  = $urandom;
      rd = 5'(1 + ($urandom % 31));
      run_inst(build_inst(k, r, rd));
    end
    r = $urandom;
    run_inst({r[31:15], 3'd0, 5'd0, 7'h13});        // ADDI to x0 writes nothing
    test_end();

    test_begin("invalid");
    r = $urandom;
    run_inst({r[31:7], 7'h7f});                      // Unknown major opcode
    run_inst(enc_r(7'h01, r[24:20], r[19:15], r[14:12], r[11:7]));
    run_inst({r[31:15], 3'd2, r[11:7], 7'h63});      // Unused branch funct3
    test_end();

    test_begin("register reads");
    wb_write(5'd5, $urandom);
    wb_write(5'd6, $urandom);
    run_inst(enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd7));
    wb_wr_reg = 1'b1;  // x8 written in the same cycle as the read
    wb_regno  = 5'd8;
    wb_regval = $urandom;
    send(enc_r(7'h00, 5'd5, 5'd8, 3'd4, 5'd9));
    wb_wr_reg = 1'b0;
    wb_write(5'd9, $urandom);
    wb_write(5'd0, $urandom);
    run_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd10));
    test_end();

    test_begin("raw hazard");
    send({12'h05a, 5'd0, 3'd0, 5'd11, 7'h13});      // ADDI x11 stays pending
    inst     = enc_r(7'h00, 5'd11, 5'd11, 3'd0, 5'd12);
    fe_valid = 1'b1;
    fe_inst  = inst;
    for (n = 0; n < 3; n++) begin
      @(negedge clk);
      check_field("stall", 32'(stall), 32'd1);  // x11 still pending
      next_cycle();
    end
    wb_write(5'd11, $urandom);
    send(inst);  // Taken in the cycle after the clear
    wb_write(5'd12, $urandom);
    test_end();

    test_begin("mispredict");
    br_mispred = 1'b1;
    fe_valid   = 1'b1;
    inst       = enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd13);
    fe_inst    = inst;
    for (n = 0; n < 3; n++) begin
      next_cycle();
      check_field("de_valid", 32'(de_valid), 32'd0);
    end
    br_mispred = 1'b0;
    send(inst);
    wb_write(5'd13, $urandom);
    test_end();

    $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
             tests, failed_tests, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* compile.f */
+incdir+tests
common/decode_pkg.sv
common/dec_if.sv
decode/inst_decoder.sv
decode/reg_file.sv
decode/issue_ctrl.sv
logic/decode_stage.sv
tests/tb_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
LINT_TOP  ?= decode_stage
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

SOURCES := $(wildcard common/*.sv decode/*.sv logic/*.sv tests/*.sv tests/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
